/* ialu.f */
rtl/ialu_isa_pkg.sv
rtl/ialu_iter_pkg.sv
rtl/ialu_iter_if.sv
rtl/ialu_ctrl_fsm.sv
rtl/ialu_step_counter.sv
rtl/ialu_fast_path.sv
rtl/ialu_muldiv_unit.sv
rtl/ialu_top.sv
tests/ialu_assert.sv
tests/tb_ialu.sv

/* Makefile */
# Verilator build and run of the integer ALU testbench
VERILATOR ?= verilator
TOP       ?= tb_ialu
FILELIST  ?= ialu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** TEST PASSED ***
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/tb_ialu.sv */
// ----------------------------------------------------------------------
// Random operations on the integer ALU, checked against a behavioral model
// Inputs change on the falling edge, outputs are sampled a quarter period later
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module tb_ialu;
    import ialu_isa_pkg::*;

    localparam int XLEN       = 32;
    localparam int SH_W       = $clog2(XLEN);
    localparam int CLK_PERIOD = 20;
    localparam int N_FAST     = 200;
    localparam int N_RAND     = 30;                 // Per opcode in the other tests
    localparam int NUM_OPS    = N_FAST + 14 * N_RAND + 24;
    localparam int WATCHDOG   = (NUM_OPS * (XLEN + 3) + 100) * CLK_PERIOD;

    logic            clk;
    logic            rst_n;
    logic            valid;
    ialu_cmd_e       cmd;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;
    logic            ready;
    logic            busy;
    logic [XLEN-1:0] result;
    logic            cmp;
    logic [31:0]     rng_state;
    int              checks;
    int              errors;

    ialu_cmd_e fast_ops [8] = '{IALU_CMD_AND, IALU_CMD_OR, IALU_CMD_XOR, IALU_CMD_ADD,
                                IALU_CMD_SUB, IALU_CMD_SLL, IALU_CMD_SRL, IALU_CMD_SRA};
    ialu_cmd_e cmp_ops [6]  = '{IALU_CMD_LT, IALU_CMD_LTU, IALU_CMD_EQ,
                                IALU_CMD_NE, IALU_CMD_GE, IALU_CMD_GEU};
    ialu_cmd_e mul_ops [4]  = '{IALU_CMD_MUL, IALU_CMD_MULH, IALU_CMD_MULHSU, IALU_CMD_MULHU};
    ialu_cmd_e div_ops [4]  = '{IALU_CMD_DIV, IALU_CMD_DIVU, IALU_CMD_REM, IALU_CMD_REMU};

    ialu_top #(.XLEN(XLEN)) dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .valid  (valid),
        .cmd    (cmd),
        .op1    (op1),
        .op2    (op2),
        .ready  (ready),
        .busy   (busy),
        .result (result),
        .cmp    (cmp)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);  // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        logic [XLEN-1:0] w;
        w = '0;
        for (int i = 0; i < XLEN; i += 32) begin
            w = (w << 32) | XLEN'(next_rand());
        end
        return w;
    endfunction

    // ------------------------------------------------------------------
    // Reference model, returns {cmp, result}
    // ------------------------------------------------------------------
    function automatic logic [XLEN:0] model(input ialu_cmd_e c, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0]   sa;
        logic signed [XLEN-1:0]   sb;
        logic signed [2*XLEN-1:0] p_ss;
        logic signed [2*XLEN-1:0] p_su;
        logic [2*XLEN-1:0]        p_uu;
        logic                     ovf;
        logic [XLEN-1:0]          r;
        logic                     f;
        sa   = $signed(a);
        sb   = $signed(b);
        p_ss = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
        p_su = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{1'b0}}, b});
        p_uu = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        ovf  = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);    // Most negative by -1
        r    = '0;
        f    = 1'b0;
        case (c)
            IALU_CMD_AND:    r = a & b;
            IALU_CMD_OR:     r = a | b;
            IALU_CMD_XOR:    r = a ^ b;
            IALU_CMD_ADD:    r = a + b;
            IALU_CMD_SUB:    r = a - b;
            IALU_CMD_SLL:    r = a << b[SH_W-1:0];
            IALU_CMD_SRL:    r = a >> b[SH_W-1:0];
            IALU_CMD_SRA:    r = sa >>> b[SH_W-1:0];
            IALU_CMD_LT:     f = sa < sb;
            IALU_CMD_LTU:    f = a < b;
            IALU_CMD_EQ:     f = a == b;
            IALU_CMD_NE:     f = a != b;
            IALU_CMD_GE:     f = sa >= sb;
            IALU_CMD_GEU:    f = a >= b;
            IALU_CMD_MUL:    r = p_uu[XLEN-1:0];
            IALU_CMD_MULH:   r = p_ss[2*XLEN-1:XLEN];
            IALU_CMD_MULHSU: r = p_su[2*XLEN-1:XLEN];
            IALU_CMD_MULHU:  r = p_uu[2*XLEN-1:XLEN];
            IALU_CMD_DIVU:   r = (b == '0) ? '1 : a / b;
            IALU_CMD_REMU:   r = (b == '0) ? a : a % b;
            IALU_CMD_DIV: begin
                if (b == '0)  r = '1;
                else if (ovf) r = a;
                else          r = sa / sb;              // Truncates toward zero
            end
            IALU_CMD_REM: begin
                if (b == '0)  r = a;
                else if (ovf) r = '0;
                else          r = sa % sb;              // Takes the dividend's sign
            end
            default: begin
            end
        endcase
        r = r | XLEN'(f);                               // Compares return the flag in bit 0
        return {f, r};
    endfunction

    // ------------------------------------------------------------------
    // One request, held until ready, then result and latency checked
    // ------------------------------------------------------------------
    task automatic check_op(input ialu_cmd_e c, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b, input bit single);
        logic [XLEN:0] exp;
        int            cycles;
        bit            done;
        exp    = model(c, a, b);
        cycles = 0;
        done   = 1'b0;
        @(negedge clk);
        valid = 1'b1;
        cmd   = c;
        op1   = a;
        op2   = b;
        while (!done && (cycles < XLEN + 3)) begin
            #(CLK_PERIOD / 4);
            cycles++;
            if (ready) begin
                done = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        checks++;
        if (!done) begin
            $display("%0t: the DUT gave no ready within %0d cycles for %s", $time, cycles,
                     c.name());
            errors++;
        end else begin
            assert ({cmp, result} == exp) else begin
                $display("[ERROR] %0t: %s a=%h b=%h got %b/%h expected %b/%h", $time, c.name(),
                         a, b, cmp, result, exp[XLEN], exp[XLEN-1:0]);
                errors++;
            end
            assert (single ? (cycles == 1) : (cycles inside {XLEN + 1, XLEN + 2})) else begin
                $display("[ERROR] %0t: %s a=%h b=%h ready after %0d cycles", $time, c.name(),
                         a, b, cycles);
                errors++;
            end
        end
    endtask

    task automatic report_test(input string name, input int c0, input int e0);
        $display("test %-8s %0d checks, %0d errors", name, checks - c0, errors - e0);
    endtask

    initial begin
        #(WATCHDOG);
        $display("watchdog expired after %0d ns, the DUT stopped responding", WATCHDOG);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int              c0;
        int              e0;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        rng_state = 32'd62493;
        checks    = 0;
        errors    = 0;
        rst_n     = 1'b0;
        valid     = 1'b0;
        cmd       = IALU_CMD_AND;
        op1       = '0;
        op2       = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        c0 = checks;
        e0 = errors;
        for (int i = 0; i < N_FAST; i++) begin
            check_op(fast_ops[next_rand() % 8], rand_word(), rand_word(), 1'b1);
        end
        report_test("fast", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int k = 0; k < 6; k++) begin
            for (int i = 0; i < N_RAND; i++) begin
                a = rand_word();
                b = (i % 4 == 0) ? a : rand_word();     // Some equal pairs
                check_op(cmp_ops[k], a, b, 1'b1);
            end
        end
        report_test("compare", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < N_RAND; i++) begin
                a = rand_word();
                b = rand_word();
                check_op(mul_ops[k], a, b, (a == '0) || (b == '0));
            end
        end
        report_test("multiply", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < N_RAND; i++) begin
                a = rand_word();
                b = rand_word() >> (next_rand() % XLEN);    // Spread of quotient sizes
                check_op(div_ops[k], a, b, (a == '0) || (b == '0));
            end
        end
        a = {1'b1, {(XLEN-1){1'b0}}};
        check_op(IALU_CMD_DIV, a, '1, 1'b0);
        check_op(IALU_CMD_REM, a, '1, 1'b0);
        report_test("divide", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            check_op(div_ops[k], rand_word(), '0, 1'b1);
            check_op(mul_ops[k], '0, rand_word(), 1'b1);
            check_op(mul_ops[k], rand_word(), '0, 1'b1);
        end
        report_test("zero", c0, e0);

        // Abort a multiply halfway, then run a divide
        c0 = checks;
        e0 = errors;
        @(negedge clk);
        valid = 1'b1;
        cmd   = IALU_CMD_MULH;
        op1   = rand_word() | 1'b1;
        op2   = rand_word() | 1'b1;
        repeat (5) @(negedge clk);
        #(CLK_PERIOD / 4);
        checks++;
        assert (busy) else begin
            $display("[ERROR] %0t: busy low during an iterative operation", $time);
            errors++;
        end
        @(negedge clk);
        valid = 1'b0;
        #(CLK_PERIOD / 4);
        checks++;
        assert (!busy && !ready) else begin
            $display("[ERROR] %0t: busy or ready still high after valid fell", $time);
            errors++;
        end
        check_op(IALU_CMD_DIV, rand_word(), (rand_word() >> 8) | 1'b1, 1'b0);
        report_test("abort", c0, e0);

        @(negedge clk);
        valid = 1'b0;
        $display("total %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* tests/ialu_assert.sv */
// ----------------------------------------------------------------------
// Concurrent checks on the iteration FSM and the ready/busy handshake
// Bound into every ialu_ctrl_fsm instance
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module ialu_assert (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       valid,
    input ialu_iter_pkg::ialu_state_e state,
    input logic                       last_step,
    input logic                       ready,
    input logic                       busy
);
    import ialu_iter_pkg::*;

    a_no_x: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(valid) && !$isunknown(state))
        else $error("valid or FSM state unknown");

    a_idle_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == IALU_ST_IDLE) && !valid) |=> (state != IALU_ST_ITER))
        else $error("IDLE moved to ITER without valid");

    a_iter_until_last: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == IALU_ST_ITER) && valid && !last_step) |=> (state == IALU_ST_ITER))
        else $error("ITER left before the last step");

    a_corr_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (state == IALU_ST_CORR) |=> (state != IALU_ST_CORR))
        else $error("CORR held for more than one cycle");

    // Busy without ready for every step but the last
    a_busy_in_iter: assert property (@(posedge clk) disable iff (!rst_n)
        ((state == IALU_ST_ITER) && valid && !last_step) |-> (busy && !ready))
        else $error("busy low or ready high before the last step");

endmodule

bind ialu_ctrl_fsm ialu_assert u_assert (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid     (valid),
    .state     (state_q),
    .last_step (iter.last_step),
    .ready     (ready),
    .busy      (busy)
);

/* rtl/ialu_top.sv */
// ----------------------------------------------------------------------
// Integer ALU top level with a valid/ready handshake
// Inputs must stay stable until ready; result and cmp hold only while ready
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module ialu_top #(
    parameter int XLEN = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid,
    input  ialu_isa_pkg::ialu_cmd_e cmd,
    input  logic [XLEN-1:0]         op1,
    input  logic [XLEN-1:0]         op2,
    output logic                    ready,
    output logic                    busy,
    output logic [XLEN-1:0]         result,
    output logic                    cmp
);

    logic [XLEN-1:0] fast_result;               // Single-cycle result into the final mux

    ialu_iter_if #(.XLEN(XLEN)) iter ();

    ialu_ctrl_fsm u_ctrl_fsm (
        .clk   (clk),
        .rst_n (rst_n),
        .valid (valid),
        .cmd   (cmd),
        .iter  (iter),
        .ready (ready),
        .busy  (busy)
    );

    ialu_step_counter #(.XLEN(XLEN)) u_step_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .iter  (iter)
    );

    ialu_fast_path #(.XLEN(XLEN)) u_fast_path (
        .cmd         (cmd),
        .op1         (op1),
        .op2         (op2),
        .fast_result (fast_result),
        .cmp         (cmp)
    );

    ialu_muldiv_unit #(.XLEN(XLEN)) u_muldiv_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .cmd         (cmd),
        .op1         (op1),
        .op2         (op2),
        .fast_result (fast_result),
        .iter        (iter),
        .result      (result)
    );

endmodule

/* rtl/ialu_muldiv_unit.sv */
// ----------------------------------------------------------------------
// Iterative multiply and restoring divide on operand magnitudes
// op1, op2 and cmd must stay stable until ready; the sign is fixed in CORR
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module ialu_muldiv_unit #(
    parameter int XLEN = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ialu_isa_pkg::ialu_cmd_e cmd,
    input  logic [XLEN-1:0]         op1,
    input  logic [XLEN-1:0]         op2,
    input  logic [XLEN-1:0]         fast_result,
    ialu_iter_if.datapath           iter,
    output logic [XLEN-1:0]         result
);
    import ialu_isa_pkg::*;
    import ialu_iter_pkg::*;

    logic              op1_signed;
    logic              op2_signed;
    logic              sign1;                   // op1 is negative and signed
    logic              sign2;
    logic              hi_sel;                  // Result from the upper half
    logic              is_rem;
    logic [XLEN-1:0]   mag1;
    logic [XLEN-1:0]   mag2;
    logic [2*XLEN-1:0] acc_q;                   // Product, or remainder:quotient
    logic [XLEN:0]     mul_sum;
    logic [2*XLEN-1:0] mul_next;
    logic [XLEN:0]     div_shift;
    logic [XLEN+1:0]   div_trial;
    logic [2*XLEN-1:0] div_next;
    logic [2*XLEN-1:0] acc_next;
    logic [2*XLEN-1:0] prod_neg;
    logic [XLEN-1:0]   acc_sel;
    logic [XLEN-1:0]   iter_res;
    logic [XLEN-1:0]   corr_res;
    logic [XLEN-1:0]   zero_res;

    // ------------------------------------------------------------------
    // Opcode decode and operand magnitudes
    // ------------------------------------------------------------------
    assign op1_signed = cmd inside {IALU_CMD_MUL, IALU_CMD_MULH, IALU_CMD_MULHSU,
                                    IALU_CMD_DIV, IALU_CMD_REM};
    assign op2_signed = cmd inside {IALU_CMD_MUL, IALU_CMD_MULH, IALU_CMD_DIV, IALU_CMD_REM};
    assign hi_sel     = cmd inside {IALU_CMD_MULH, IALU_CMD_MULHSU, IALU_CMD_MULHU,
                                    IALU_CMD_REM, IALU_CMD_REMU};
    assign is_rem     = cmd inside {IALU_CMD_REM, IALU_CMD_REMU};

    assign sign1 = op1_signed & op1[XLEN-1];
    assign sign2 = op2_signed & op2[XLEN-1];
    assign mag1  = sign1 ? -op1 : op1;          // Most negative value stays as unsigned
    assign mag2  = sign2 ? -op2 : op2;

    assign iter.zero_operand = ~|op1 | ~|op2;

    always_comb begin
        case (iter.op_class)
            IALU_CLS_MUL: iter.neg_result = sign1 ^ sign2;
            IALU_CLS_DIV: iter.neg_result = is_rem ? sign1 : (sign1 ^ sign2);
            default:      iter.neg_result = 1'b0;
        endcase
    end

    // ------------------------------------------------------------------
    // One step per ITER cycle
    // ------------------------------------------------------------------
    // Shift-add, multiplier bits leave from the bottom of acc_q
    assign mul_sum  = {1'b0, acc_q[2*XLEN-1:XLEN]} + (acc_q[0] ? {1'b0, mag1} : '0);
    assign mul_next = {mul_sum, acc_q[XLEN-1:1]};

    // Restoring divide, quotient bits enter at the bottom
    assign div_shift = acc_q[2*XLEN-1:XLEN-1];
    assign div_trial = {1'b0, div_shift} - {2'b00, mag2};
    assign div_next  = div_trial[XLEN+1] ? {div_shift[XLEN-1:0], acc_q[XLEN-2:0], 1'b0}
                                         : {div_trial[XLEN-1:0], acc_q[XLEN-2:0], 1'b1};

    assign acc_next = (iter.op_class == IALU_CLS_DIV) ? div_next : mul_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else begin
            case (iter.state)
                IALU_ST_IDLE: begin
                    acc_q <= {{XLEN{1'b0}}, (iter.op_class == IALU_CLS_DIV) ? mag1 : mag2};
                end
                IALU_ST_ITER: acc_q <= acc_next;
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------------------------
    // Sign fix and result select
    // ------------------------------------------------------------------
    assign iter_res = hi_sel ? acc_next[2*XLEN-1:XLEN] : acc_next[XLEN-1:0];
    assign acc_sel  = hi_sel ? acc_q[2*XLEN-1:XLEN] : acc_q[XLEN-1:0];
    assign prod_neg = -acc_q;                   // Full width for the high product half
    assign corr_res = ((iter.op_class == IALU_CLS_MUL) && hi_sel) ? prod_neg[2*XLEN-1:XLEN]
                                                                   : -acc_sel;

    // Divide by zero gives all ones, remainder keeps the dividend
    assign zero_res = (iter.op_class != IALU_CLS_DIV) ? '0 :
                      is_rem                          ? op1 :
                      (|op2)                          ? '0 : '1;

    always_comb begin
        if (iter.op_class == IALU_CLS_NONE) begin
            result = fast_result;
        end else begin
            case (iter.state)
                IALU_ST_IDLE: result = zero_res;
                IALU_ST_ITER: result = iter.last_step ? iter_res : '0;
                IALU_ST_CORR: result = corr_res;
                default:      result = '0;
            endcase
        end
    end

endmodule

/* rtl/ialu_fast_path.sv */
// ----------------------------------------------------------------------
// Single-cycle logic, add/sub, compare and shift operations
// Shift amount is the low log2(XLEN) bits of op2; cmp is 0 outside compares
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module ialu_fast_path #(
    parameter int XLEN = 32
) (
    input  ialu_isa_pkg::ialu_cmd_e cmd,
    input  logic [XLEN-1:0]         op1,
    input  logic [XLEN-1:0]         op2,
    output logic [XLEN-1:0]         fast_result,
    output logic                    cmp
);
    import ialu_isa_pkg::*;

    localparam int SH_W = $clog2(XLEN);

    logic            sub;
    logic [XLEN:0]   sum;                       // Carry in the top bit
    ialu_flags_s     flags;
    logic [SH_W-1:0] shamt;
    logic [XLEN-1:0] shift_res;

    // ------------------------------------------------------------------
    // Adder, shared by add, sub and all compares
    // ------------------------------------------------------------------
    assign sub = (cmd != IALU_CMD_ADD);
    assign sum = sub ? ({1'b0, op1} - {1'b0, op2}) : ({1'b0, op1} + {1'b0, op2});

    assign flags.z = ~|sum[XLEN-1:0];
    assign flags.s = sum[XLEN-1];
    assign flags.c = sum[XLEN];                 // Borrow when subtracting
    assign flags.o = (op1[XLEN-1] == (op2[XLEN-1] ^ sub)) & (sum[XLEN-1] != op1[XLEN-1]);

    // ------------------------------------------------------------------
    // Shifter
    // ------------------------------------------------------------------
    assign shamt = op2[SH_W-1:0];

    always_comb begin
        case (cmd)
            IALU_CMD_SRL: shift_res = op1 >> shamt;
            IALU_CMD_SRA: shift_res = $unsigned($signed(op1) >>> shamt);
            default:      shift_res = op1 << shamt;
        endcase
    end

    // ------------------------------------------------------------------
    // Result select
    // ------------------------------------------------------------------
    always_comb begin
        fast_result = '0;
        cmp         = 1'b0;
        case (cmd)
            IALU_CMD_AND: fast_result = op1 & op2;
            IALU_CMD_OR:  fast_result = op1 | op2;
            IALU_CMD_XOR: fast_result = op1 ^ op2;
            IALU_CMD_ADD,
            IALU_CMD_SUB: fast_result = sum[XLEN-1:0];
            IALU_CMD_LT:  cmp = flags.s ^ flags.o;
            IALU_CMD_LTU: cmp = flags.c;
            IALU_CMD_EQ:  cmp = flags.z;
            IALU_CMD_NE:  cmp = ~flags.z;
            IALU_CMD_GE:  cmp = ~(flags.s ^ flags.o);
            IALU_CMD_GEU: cmp = ~flags.c;
            IALU_CMD_SLL,
            IALU_CMD_SRL,
            IALU_CMD_SRA: fast_result = shift_res;
            default: begin
            end
        endcase
        if (cmd inside {IALU_CMD_LT, IALU_CMD_LTU, IALU_CMD_EQ,
                        IALU_CMD_NE, IALU_CMD_GE, IALU_CMD_GEU}) begin
            fast_result = XLEN'(cmp);           // Flag in bit 0
        end
    end

endmodule

/* rtl/ialu_step_counter.sv */
// ----------------------------------------------------------------------
// Iteration step counter, XLEN steps per multiply or divide
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module ialu_step_counter #(
    parameter int XLEN = 32
) (
    input  logic          clk,
    input  logic          rst_n,
    ialu_iter_if.counter  iter
);
    import ialu_iter_pkg::*;

    localparam int CNT_W = $clog2(XLEN);

    logic [CNT_W-1:0] cnt_q;                    // Steps left after this one

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if ((iter.state == IALU_ST_IDLE) && (iter.op_class != IALU_CLS_NONE)) begin
            cnt_q <= CNT_W'(XLEN - 1);          // Preload while the request waits
        end else if (iter.state == IALU_ST_ITER) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Combinational so the datapath can finish in the same cycle
    assign iter.last_step = (iter.state == IALU_ST_ITER) && (cnt_q == '0);

endmodule

/* rtl/ialu_ctrl_fsm.sv */
// ----------------------------------------------------------------------
// IDLE/ITER/CORR control of the iterative path, with the ready/busy handshake
// Dropping valid aborts the operation on the next edge
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module ialu_ctrl_fsm (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid,
    input  ialu_isa_pkg::ialu_cmd_e cmd,
    ialu_iter_if.fsm                iter,
    output logic                    ready,
    output logic                    busy
);
    import ialu_isa_pkg::*;
    import ialu_iter_pkg::*;

    ialu_state_e state_q;
    ialu_state_e state_d;

    assign iter.state    = state_q;
    assign iter.op_class = is_mul(cmd) ? IALU_CLS_MUL :
                           is_div(cmd) ? IALU_CLS_DIV : IALU_CLS_NONE;

    // ------------------------------------------------------------------
    // State transitions
    // ------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            IALU_ST_IDLE: begin
                if ((iter.op_class != IALU_CLS_NONE) && !iter.zero_operand) begin
                    state_d = IALU_ST_ITER;
                end
            end
            IALU_ST_ITER: begin
                if (iter.last_step) begin
                    state_d = iter.neg_result ? IALU_ST_CORR : IALU_ST_IDLE;
                end
            end
            default: begin
                state_d = IALU_ST_IDLE;         // CORR lasts one cycle
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IALU_ST_IDLE;
        end else if (!valid) begin
            state_q <= IALU_ST_IDLE;            // Abort
        end else begin
            state_q <= state_d;
        end
    end

    // ------------------------------------------------------------------
    // Handshake
    // ------------------------------------------------------------------
    always_comb begin
        case (state_q)
            IALU_ST_IDLE: ready = valid & ((iter.op_class == IALU_CLS_NONE) | iter.zero_operand);
            IALU_ST_ITER: ready = valid & iter.last_step & ~iter.neg_result;
            IALU_ST_CORR: ready = valid;
            default:      ready = 1'b0;
        endcase
    end

    assign busy = valid & ~ready;

endmodule

/* rtl/ialu_iter_if.sv */
// ----------------------------------------------------------------------
// Iteration control between FSM, step counter and multiply/divide unit
// XLEN must be a power of two of at least 8
// ----------------------------------------------------------------------
`timescale 1ns/1ps

interface ialu_iter_if #(
    parameter int XLEN = 32
);
    import ialu_iter_pkg::*;

    ialu_state_e state;             // Current FSM state
    ialu_class_e op_class;          // Class of the pending opcode
    logic        zero_operand;      // op1 or op2 is zero
    logic        neg_result;        // Result needs the sign fix
    logic        last_step;         // Final iteration cycle

    if ((XLEN < 8) || ((XLEN & (XLEN - 1)) != 0)) begin : g_xlen_check
        $error("ialu_iter_if: XLEN must be a power of two, at least 8");
    end

    modport fsm (
        output state,
        output op_class,
        input  zero_operand,
        input  neg_result,
        input  last_step
    );

    modport counter (
        input  state,
        input  op_class,
        output last_step
    );

    modport datapath (
        input  state,
        input  op_class,
        input  last_step,
        output zero_operand,
        output neg_result
    );

endinterface

/* rtl/ialu_iter_pkg.sv */
// ----------------------------------------------------------------------
// Types shared by the iteration control and the multiply/divide datapath
// ----------------------------------------------------------------------
package ialu_iter_pkg;

    // Iteration FSM states
    typedef enum logic [1:0] {
        IALU_ST_IDLE,               // Waiting, or single-cycle work
        IALU_ST_ITER,               // One bit per cycle
        IALU_ST_CORR                // Sign fix of the result
    } ialu_state_e;

    // Operation class decoded from the opcode
    typedef enum logic [1:0] {
        IALU_CLS_NONE,
        IALU_CLS_MUL,
        IALU_CLS_DIV
    } ialu_class_e;

endpackage

/* rtl/ialu_isa_pkg.sv */
// ----------------------------------------------------------------------
// Opcode set, flag layout and opcode class helpers of the integer ALU
// Opcode encodings are not fixed, so compare opcodes by name only
// ----------------------------------------------------------------------
package ialu_isa_pkg;

    typedef enum logic [4:0] {
        IALU_CMD_AND,               // Logic
        IALU_CMD_OR,
        IALU_CMD_XOR,
        IALU_CMD_ADD,               // Add and subtract
        IALU_CMD_SUB,
        IALU_CMD_LT,                // Compares
        IALU_CMD_LTU,
        IALU_CMD_EQ,
        IALU_CMD_NE,
        IALU_CMD_GE,
        IALU_CMD_GEU,
        IALU_CMD_SLL,               // Shifts
        IALU_CMD_SRL,
        IALU_CMD_SRA,
        IALU_CMD_MUL,               // Multiply, low half
        IALU_CMD_MULH,              // High half of the three signedness variants
        IALU_CMD_MULHSU,
        IALU_CMD_MULHU,
        IALU_CMD_DIV,               // Divide and remainder
        IALU_CMD_DIVU,
        IALU_CMD_REM,
        IALU_CMD_REMU
    } ialu_cmd_e;

    typedef struct packed {
        logic z;                    // Zero
        logic s;                    // Sign
        logic o;                    // Signed overflow
        logic c;                    // Carry out or borrow
    } ialu_flags_s;

    function automatic logic is_mul(input ialu_cmd_e cmd);
        return cmd inside {IALU_CMD_MUL, IALU_CMD_MULH, IALU_CMD_MULHSU, IALU_CMD_MULHU};
    endfunction

    function automatic logic is_div(input ialu_cmd_e cmd);
        return cmd inside {IALU_CMD_DIV, IALU_CMD_DIVU, IALU_CMD_REM, IALU_CMD_REMU};
    endfunction

endpackage
